//--- bridge_pkg.sv
/* chip to memory bridge
   shared widths and types */

`default_nettype none

package bridge_pkg;

    // ==============================
    // widths
    // ==============================

    // chip data port and bus data
    localparam int DATA_W = 64;
    // word address field of a command word
    localparam int ADDR_W = 32;
    // memory depth in word address bits
    localparam int MEM_AW = 10;
    // 8 bytes per word on the bus
    localparam int BYTE_SHIFT = 3;

    // ==============================
    // types
    // ==============================

    typedef logic [DATA_W-1:0] data_word_t;
    typedef logic [ADDR_W-1:0] word_addr_t;
    typedef logic [31:0]       bus_addr_t;
    typedef logic [1:0]        htrans_t;

    // transfer type codes as on AHB
    localparam htrans_t HTRANS_IDLE   = 2'b00;
    localparam htrans_t HTRANS_NONSEQ = 2'b10;
    localparam htrans_t HTRANS_SEQ    = 2'b11;

    // bridge FSM
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CMD,
        ST_TO_CHIP,
        ST_TO_MEM
    } port_state_e;

    // command word layout
    // dir bit set means chip writes to memory
    localparam int CMD_DIR_BIT  = 0;
    localparam int CMD_ADDR_LSB = 1;

endpackage

`default_nettype wire

//--- chip_port_fsm.sv
/* chip port FSM
   command decode and bus request generation */

`timescale 1ns/1ps
`default_nettype none

module chip_port_fsm (
    input  logic                   clk,
    input  logic                   rst_n,
    // chip side
    input  logic                   i_cmd_vld,
    input  logic                   i_dat_oe,
    input  logic                   i_dat_vld,
    input  logic                   i_dat_rdy,
    input  bridge_pkg::data_word_t i_dat,
    output bridge_pkg::data_word_t o_dat,
    output logic                   o_dat_vld,
    output logic                   o_dat_rdy,
    output logic                   o_busy,
    // bus master side
    output bridge_pkg::bus_addr_t  o_haddr,
    output bridge_pkg::htrans_t    o_htrans,
    output logic                   o_hwrite,
    output bridge_pkg::data_word_t o_hwdata,
    input  logic                   i_hready,
    input  logic                   i_hresp,
    input  bridge_pkg::data_word_t i_hrdata
);

    import bridge_pkg::*;

    port_state_e state_q;
    port_state_e state_d;

    // word address of the next bus transfer
    word_addr_t addr_q;
    // next transfer is the first after a command
    logic       first_q;
    // read data phase outstanding
    logic       rd_pend_q;

    // chip output register
    data_word_t out_dat_q;
    logic       out_vld_q;

    // write data for the data phase
    data_word_t hwdata_q;

    logic cmd_acc;
    logic wr_req;
    logic wr_acc;
    logic rd_issue;
    logic rd_done;
    logic rd_load;
    logic out_take;
    logic bus_req;
    logic ap_take;

    // ==============================
    // handshakes
    // ==============================

    // command word comes from the chip
    assign cmd_acc  = (state_q == ST_CMD) && i_dat_oe && i_dat_vld;

    // word leaves the output register
    assign out_take = out_vld_q && i_dat_rdy && !i_dat_oe;

    // write request straight from the chip word
    // held off while the slave flags an error
    assign wr_req = (state_q == ST_TO_MEM) && i_dat_oe && i_dat_vld && !i_hresp;
    assign wr_acc = wr_req && i_hready;

    // one read at a time
    // only when the output register has room
    assign rd_issue = (state_q == ST_TO_CHIP) && !i_cmd_vld && !rd_pend_q && !i_hresp
                      && (!out_vld_q || out_take);

    // data phase of the outstanding read ends
    assign rd_done = rd_pend_q && i_hready;
    // stale read after close is dropped here
    assign rd_load = rd_done && (state_q == ST_TO_CHIP) && !i_cmd_vld;

    assign o_dat_rdy = (state_q == ST_CMD)
                       || ((state_q == ST_TO_MEM) && i_hready && !i_hresp);
    assign o_dat_vld = out_vld_q;
    assign o_dat     = out_dat_q;
    assign o_busy    = (state_q != ST_IDLE);

    // ==============================
    // bus address phase
    // ==============================

    assign bus_req  = wr_req || rd_issue;
    assign ap_take  = bus_req && i_hready;

    assign o_htrans = !bus_req ? HTRANS_IDLE : (first_q ? HTRANS_NONSEQ : HTRANS_SEQ);
    assign o_hwrite = (state_q == ST_TO_MEM);
    // word to byte address
    assign o_haddr  = addr_q << BYTE_SHIFT;
    assign o_hwdata = hwdata_q;

    // ==============================
    // FSM
    // ==============================

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (i_cmd_vld) begin
                    state_d = ST_CMD;
                end
            end
            ST_CMD: begin
                // strobe before any command word aborts
                if (i_cmd_vld) begin
                    state_d = ST_IDLE;
                end else if (cmd_acc) begin
                    state_d = i_dat[CMD_DIR_BIT] ? ST_TO_MEM : ST_TO_CHIP;
                end
            end
            ST_TO_CHIP, ST_TO_MEM: begin
                // closing strobe
                if (i_cmd_vld) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= ST_IDLE;
            addr_q    <= '0;
            first_q   <= 1'b0;
            rd_pend_q <= 1'b0;
            out_vld_q <= 1'b0;
        end else begin
            state_q <= state_d;

            // address counter
            if (cmd_acc) begin
                addr_q <= i_dat[CMD_ADDR_LSB +: ADDR_W];
            end else if (ap_take) begin
                addr_q <= addr_q + 1'b1;
            end

            // NONSEQ once per command
            if (cmd_acc) begin
                first_q <= 1'b1;
            end else if (ap_take) begin
                first_q <= 1'b0;
            end

            // read tracking survives close until its data phase ends
            if (ap_take && !o_hwrite) begin
                rd_pend_q <= 1'b1;
            end else if (rd_done) begin
                rd_pend_q <= 1'b0;
            end

            // output valid
            if ((state_q != ST_TO_CHIP) || i_cmd_vld) begin
                out_vld_q <= 1'b0;
            end else if (rd_load) begin
                out_vld_q <= 1'b1;
            end else if (out_take) begin
                out_vld_q <= 1'b0;
            end
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (rd_load) begin
            out_dat_q <= i_hrdata;
        end
        // captured with the address phase
        if (wr_acc) begin
            hwdata_q <= i_dat;
        end
    end

endmodule

`default_nettype wire

//--- ahb_ram_slave.sv
/* AHB-lite RAM slave
   random wait states */

`timescale 1ns/1ps
`default_nettype none

module ahb_ram_slave (
    input  logic                   clk,
    input  logic                   rst_n,
    input  bridge_pkg::bus_addr_t  i_haddr,
    input  bridge_pkg::htrans_t    i_htrans,
    input  logic                   i_hwrite,
    input  bridge_pkg::data_word_t i_hwdata,
    output bridge_pkg::data_word_t o_hrdata,
    output logic                   o_hready,
    output logic                   o_hresp
);

    import bridge_pkg::*;

    // ==============================
    // storage
    // ==============================

    // stands in for the board DDR
    data_word_t mem [2**MEM_AW];

    // wait state source
    logic [15:0] lfsr_q;
    logic        lfsr_fb;

    // data phase state
    logic              dp_vld_q;
    logic              dp_waited_q;
    logic              dp_write_q;
    logic [MEM_AW-1:0] dp_addr_q;

    logic ap_take;
    logic dp_end;

    // ==============================
    // wait states
    // ==============================

    // x^16 + x^14 + x^13 + x^11
    assign lfsr_fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];

    // at most one extra cycle per data phase
    assign o_hready = !(dp_vld_q && !dp_waited_q && lfsr_q[0]);

    // address phase on active transfer with ready
    assign ap_take = ((i_htrans == HTRANS_NONSEQ) || (i_htrans == HTRANS_SEQ)) && o_hready;
    assign dp_end  = dp_vld_q && o_hready;

    // never an error
    assign o_hresp = 1'b0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr_q      <= 16'hace1;
            dp_vld_q    <= 1'b0;
            dp_waited_q <= 1'b0;
        end else begin
            // free running
            lfsr_q <= {lfsr_q[14:0], lfsr_fb};

            if (ap_take) begin
                dp_vld_q <= 1'b1;
            end else if (dp_end) begin
                dp_vld_q <= 1'b0;
            end

            // remember the wait so the phase ends next cycle
            if (ap_take || dp_end) begin
                dp_waited_q <= 1'b0;
            end else if (dp_vld_q && !o_hready) begin
                dp_waited_q <= 1'b1;
            end
        end
    end

    // ==============================
    // address phase capture
    // ==============================

    always_ff @(posedge clk) begin
        if (ap_take) begin
            dp_write_q <= i_hwrite;
            // drop byte offset, keep word bits
            dp_addr_q  <= i_haddr[BYTE_SHIFT +: MEM_AW];
        end
    end

    // ==============================
    // RAM access
    // ==============================

    // write lands on the edge that ends the data phase
    always_ff @(posedge clk) begin
        if (dp_end && dp_write_q) begin
            mem[dp_addr_q] <= i_hwdata;
        end
    end

    // read path
    // valid when hready rises in the data phase
    assign o_hrdata = mem[dp_addr_q];

endmodule

`default_nettype wire

//--- chip_mem_bridge_top.sv
/* chip to memory bridge top */

`timescale 1ns/1ps
`default_nettype none

module chip_mem_bridge_top (
    input  logic                   clk,
    input  logic                   rst_n,
    // chip side
    input  logic                   i_cmd_vld,
    input  logic                   i_dat_oe,
    input  logic                   i_dat_vld,
    input  logic                   i_dat_rdy,
    input  bridge_pkg::data_word_t i_dat,
    output bridge_pkg::data_word_t o_dat,
    output logic                   o_dat_vld,
    output logic                   o_dat_rdy,
    output logic                   o_busy
);

    import bridge_pkg::*;

    // ==============================
    // internal bus
    // ==============================

    bus_addr_t  haddr;
    htrans_t    htrans;
    logic       hwrite;
    data_word_t hwdata;
    data_word_t hrdata;
    logic       hready;
    logic       hresp;

    // bus master facing the chip
    chip_port_fsm u_chip_port_fsm (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_cmd_vld (i_cmd_vld),
        .i_dat_oe  (i_dat_oe),
        .i_dat_vld (i_dat_vld),
        .i_dat_rdy (i_dat_rdy),
        .i_dat     (i_dat),
        .o_dat     (o_dat),
        .o_dat_vld (o_dat_vld),
        .o_dat_rdy (o_dat_rdy),
        .o_busy    (o_busy),
        .o_haddr   (haddr),
        .o_htrans  (htrans),
        .o_hwrite  (hwrite),
        .o_hwdata  (hwdata),
        .i_hready  (hready),
        .i_hresp   (hresp),
        .i_hrdata  (hrdata)
    );

    // memory behind the bus
    ahb_ram_slave u_ahb_ram_slave (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_haddr  (haddr),
        .i_htrans (htrans),
        .i_hwrite (hwrite),
        .i_hwdata (hwdata),
        .o_hrdata (hrdata),
        .o_hready (hready),
        .o_hresp  (hresp)
    );

endmodule

`default_nettype wire

//--- tb_chip_mem_bridge.sv
/* chip to memory bridge testbench */

`timescale 1ns/1ps
`default_nettype none

module tb_chip_mem_bridge;

    import bridge_pkg::*;

    // character codes seen by the file parser
    localparam int CH_EOF  = -1;
    localparam int CH_LF   = 10;
    localparam int CH_HASH = 35;
    localparam int CH_R    = 82;
    localparam int CH_W    = 87;

    logic       clk;
    logic       rst_n;
    logic       i_cmd_vld;
    logic       i_dat_oe;
    logic       i_dat_vld;
    logic       i_dat_rdy;
    data_word_t i_dat;
    data_word_t o_dat;
    logic       o_dat_vld;
    logic       o_dat_rdy;
    logic       o_busy;

    // records from the vector file
    int         rec_kind  [$];
    word_addr_t rec_addr  [$];
    int         rec_cnt   [$];
    int         rec_gap   [$];
    data_word_t rec_words [$];

    // expected memory contents of written words
    data_word_t ref_mem [word_addr_t];
    int         wd_limit  = 0;

    chip_mem_bridge_top chip_mem_bridge_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_cmd_vld (i_cmd_vld),
        .i_dat_oe  (i_dat_oe),
        .i_dat_vld (i_dat_vld),
        .i_dat_rdy (i_dat_rdy),
        .i_dat     (i_dat),
        .o_dat     (o_dat),
        .o_dat_vld (o_dat_vld),
        .o_dat_rdy (o_dat_rdy),
        .o_busy    (o_busy)
    );

    // 20 ns period
    always #10 clk = ~clk;

    // ==============================
    // checks
    // ==============================

    task automatic fail_run(input string why);
        $display(">>> FAIL");
        $fatal(1, "%s", why);
    endtask

    task automatic check_word(input data_word_t got, input data_word_t exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t: %s got %h expected %h", $time, what, got, exp);
            fail_run("data word mismatch");
        end
    endtask

    task automatic check_busy(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t: o_busy %s got %b expected %b", $time, what, got, exp);
            fail_run("busy level mismatch");
        end
    endtask

    // ==============================
    // vector file
    // ==============================

    task automatic load_tests;
        int         fd;
        int         c;
        int         cnt;
        int         gap;
        word_addr_t a;
        data_word_t w;
        fd = $fopen("bridge_tests.txt", "r");
        if (fd == 0) begin
            fail_run("could not open bridge_tests.txt");
        end
        c = $fgetc(fd);
        while (c != CH_EOF) begin
            if (c == CH_HASH) begin
                // comment up to end of line
                while (c != CH_EOF && c != CH_LF) begin
                    c = $fgetc(fd);
                end
            end else if (c == CH_W || c == CH_R) begin
                if ($fscanf(fd, "%h %d %d", a, cnt, gap) != 3) begin
                    fail_run("malformed record header in bridge_tests.txt");
                end
                rec_kind.push_back(c);
                rec_addr.push_back(a);
                rec_cnt.push_back(cnt);
                rec_gap.push_back(gap);
                for (int i = 0; i < cnt; i++) begin
                    if ($fscanf(fd, "%h", w) != 1) begin
                        fail_run("bridge_tests.txt ends inside a record");
                    end
                    rec_words.push_back(w);
                end
            end else if (c > 32) begin
                fail_run("unexpected character in bridge_tests.txt");
            end
            c = $fgetc(fd);
        end
        $fclose(fd);
    endtask

    // ==============================
    // chip side sequences
    // ==============================

    // strobe then command word with dir bit and word address
    task automatic open_transfer(input logic to_mem, input word_addr_t addr);
        data_word_t cmd;
        cmd = '0;
        cmd[CMD_DIR_BIT] = to_mem;
        cmd[CMD_ADDR_LSB +: ADDR_W] = addr;
        @(negedge clk);
        i_cmd_vld = 1'b1;
        i_dat_vld = 1'b0;
        i_dat_rdy = 1'b0;
        #1;
        check_busy(o_busy, 1'b0, "before opening strobe");
        @(negedge clk);
        i_cmd_vld = 1'b0;
        i_dat_oe  = 1'b1;
        i_dat_vld = 1'b1;
        i_dat     = cmd;
        #1;
        check_busy(o_busy, 1'b1, "after opening strobe");
        while (!o_dat_rdy) begin
            @(negedge clk);
            #1;
        end
    endtask

    task automatic close_transfer;
        @(negedge clk);
        i_cmd_vld = 1'b1;
        i_dat_vld = 1'b0;
        i_dat_rdy = 1'b0;
        #1;
        check_busy(o_busy, 1'b1, "in closing cycle");
        @(negedge clk);
        i_cmd_vld = 1'b0;
        i_dat_oe  = 1'b0;
        #1;
        check_busy(o_busy, 1'b0, "after closing strobe");
    endtask

    task automatic run_write(input word_addr_t addr, input int cnt, input int gap, input int base);
        int         n_gap;
        data_word_t w;
        open_transfer(1'b1, addr);
        for (int i = 0; i < cnt; i++) begin
            w = rec_words[base + i];
            n_gap = (gap != 0) ? int'($urandom % 3) : 0;
            // idle cycles carry junk that must not be stored
            repeat (n_gap) begin
                @(negedge clk);
                i_dat_vld = 1'b0;
                i_dat     = ~w;
                #1;
                check_busy(o_busy, 1'b1, "during write gap");
            end
            @(negedge clk);
            i_dat_vld = 1'b1;
            i_dat     = w;
            #1;
            // word and valid held until ready
            while (!o_dat_rdy) begin
                @(negedge clk);
                #1;
            end
            ref_mem[addr + word_addr_t'(i)] = w;
        end
        close_transfer();
    endtask

    task automatic run_read(input word_addr_t addr, input int cnt, input int gap, input int base);
        data_word_t exp [$];
        data_word_t held_dat;
        word_addr_t a;
        logic       held;
        logic       rdy;
        int         got;
        // file expectation against the model
        for (int i = 0; i < cnt; i++) begin
            a = addr + word_addr_t'(i);
            if (!ref_mem.exists(a)) begin
                fail_run("read record expects a word that was never written");
            end
            check_word(rec_words[base + i], ref_mem[a], "file expectation vs model");
            exp.push_back(ref_mem[a]);
        end
        open_transfer(1'b0, addr);
        got      = 0;
        held     = 1'b0;
        held_dat = '0;
        while (got < cnt) begin
            @(negedge clk);
            rdy = (gap == 0) || (($urandom % 4) != 0);
            i_dat_oe  = 1'b0;
            i_dat_vld = 1'b0;
            i_dat_rdy = rdy;
            #1;
            check_busy(o_busy, 1'b1, "during read burst");
            // word refused last cycle must still be there
            if (held) begin
                if (o_dat_vld !== 1'b1) begin
                    $display("** Error at %0t: o_dat_vld dropped before the word was taken",
                             $time);
                    fail_run("read word lost under back-pressure");
                end
                check_word(o_dat, held_dat, "held o_dat");
            end
            if (o_dat_vld && rdy) begin
                check_word(o_dat, exp[got], "read data");
                got++;
                held = 1'b0;
            end else begin
                held     = o_dat_vld;
                held_dat = o_dat;
            end
        end
        close_transfer();
    endtask

    // ==============================
    // main sequence and watchdog
    // ==============================

    initial begin
        int base;
        clk       = 1'b0;
        rst_n     = 1'b0;
        i_cmd_vld = 1'b0;
        i_dat_oe  = 1'b0;
        i_dat_vld = 1'b0;
        i_dat_rdy = 1'b0;
        i_dat     = '0;
        void'($urandom(44897));
        load_tests();
        wd_limit = 200 * rec_words.size() + 1000;
        $display("loaded %0d records with %0d words", rec_kind.size(), rec_words.size());
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #1;
        check_busy(o_busy, 1'b0, "after reset");
        if (o_dat_vld !== 1'b0 || o_dat_rdy !== 1'b0) begin
            $display("** Error at %0t: o_dat_vld or o_dat_rdy high after reset", $time);
            fail_run("bad state after reset");
        end
        base = 0;
        foreach (rec_kind[r]) begin
            if (rec_kind[r] == CH_W) begin
                run_write(rec_addr[r], rec_cnt[r], rec_gap[r], base);
            end else begin
                run_read(rec_addr[r], rec_cnt[r], rec_gap[r], base);
            end
            base += rec_cnt[r];
        end
        $display(">>> PASS");
        $finish;
    end

    // budget scales with the words in the file
    initial begin
        wait (wd_limit != 0);
        repeat (wd_limit) @(posedge clk);
        $display("watchdog expired after %0d cycles, the bridge stopped responding", wd_limit);
        fail_run("simulation hang");
    end

endmodule

`default_nettype wire

//--- bridge_tests.txt
# kind W or R, start word address in hex, word count, gap mode (1 = random gaps)
# then count 64-bit hex words, data to write for W and expected readback for R
W 010 8 0
0123456789abcdef fedcba9876543210 0000000000000000 ffffffffffffffff
5555aaaa5555aaaa aaaa5555aaaa5555 8000000000000001 7ffffffffffffffe
R 010 8 0
0123456789abcdef fedcba9876543210 0000000000000000 ffffffffffffffff
5555aaaa5555aaaa aaaa5555aaaa5555 8000000000000001 7ffffffffffffffe
W 100 8 1
c0de000000000100 c0de000000000101 c0de000000000102 c0de000000000103
c0de000000000104 c0de000000000105 c0de000000000106 c0de000000000107
R 103 4 0
c0de000000000103 c0de000000000104 c0de000000000105 c0de000000000106
R 100 8 1
c0de000000000100 c0de000000000101 c0de000000000102 c0de000000000103
c0de000000000104 c0de000000000105 c0de000000000106 c0de000000000107
W 104 2 1
beef000000000104 beef000000000105
R 100 8 1
c0de000000000100 c0de000000000101 c0de000000000102 c0de000000000103
beef000000000104 beef000000000105 c0de000000000106 c0de000000000107

//--- sim.f
bridge_pkg.sv
chip_port_fsm.sv
ahb_ram_slave.sv
chip_mem_bridge_top.sv
tb_chip_mem_bridge.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0
TOP       ?= tb_chip_mem_bridge
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q ">>> PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
